//--- common/bilin_consts.svh
// ==========================================================================
// Bilinear scaler constants
// Fixed frame geometry, memory widths and the Q8.8 step default
// ==========================================================================

`ifndef BILIN_CONSTS_SVH
`define BILIN_CONSTS_SVH

// Input frame, 8x8 pixels
`define BILIN_IN_W      8
`define BILIN_IN_H      8
// Output frame, 16x16 pixels
`define BILIN_OUT_W     16
`define BILIN_OUT_H     16

// One pixel per byte, four pixels per memory word
`define BILIN_PIX_W     8
`define BILIN_WORD_W    32

// Byte address widths of the two frames
`define BILIN_IN_AW     6
`define BILIN_OUT_AW    8

// Q8.8 step, 0.5 after reset
`define BILIN_STEP_W    16
`define BILIN_STEP_RST  16'h0080

`endif

//--- common/bilin_pkg.sv
// ==========================================================================
// Bilinear scaler package
// Host target and core state encodings, address and data types
// ==========================================================================

`default_nettype none

`include "bilin_consts.svh"

package bilin_pkg;

  // Host port targets
  typedef enum logic [1:0] {
    TGT_IN_MEM,
    TGT_OUT_MEM,
    TGT_STEP,
    TGT_START
  } host_tgt_e;

  // Core FSM, one pass per output pixel
  typedef enum logic [2:0] {
    CORE_IDLE,
    CORE_ADDR,
    CORE_RD_X0,
    CORE_RD_X1,
    CORE_CALC,
    CORE_WRITE
  } core_state_e;

  // Byte addresses into the two frames
  typedef logic [`BILIN_IN_AW-1:0]  in_addr_t;
  typedef logic [`BILIN_OUT_AW-1:0] out_addr_t;

  typedef logic [`BILIN_PIX_W-1:0]  pix_t;
  typedef logic [`BILIN_WORD_W-1:0] word_t;

endpackage

`default_nettype wire

//--- common/pix_rd_if.sv
// ==========================================================================
// Two-port wide read link between the bilinear core and a frame memory
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "bilin_consts.svh"

interface pix_rd_if;
  import bilin_pkg::*;

  // Word indices, sized for the larger output frame
  logic [`BILIN_OUT_AW-3:0] raddr0;
  logic [`BILIN_OUT_AW-3:0] raddr1;
  // Read data, one cycle after the address
  word_t                    rdata0;
  word_t                    rdata1;

  modport core (output raddr0, output raddr1, input rdata0, input rdata1);
  modport mem  (input raddr0, input raddr1, output rdata0, output rdata1);

endinterface

`default_nettype wire

//--- hw/start_debounce.sv
// ==========================================================================
// Start switch debounce
// Two-flop synchronizer, saturating stability counter, rising-edge pulse
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

module start_debounce #(
  parameter int DEB_W = 20
) (
  input  logic i_clk_50,
  input  logic i_rst_n,
  input  logic i_sw,
  output logic o_level,
  output logic o_pulse
);

  logic             sw_meta;
  logic             sw_sync;
  logic [DEB_W-1:0] deb_cnt;
  logic             level_q;

  always_ff @(posedge i_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sw_meta <= 1'b0;
      sw_sync <= 1'b0;
      deb_cnt <= '0;
      o_level <= 1'b0;
      level_q <= 1'b0;
      o_pulse <= 1'b0;
    end else begin
      // Switch crosses in from an asynchronous pin
      sw_meta <= i_sw;
      sw_sync <= sw_meta;
      // Counts only while the input disagrees with the level
      if (sw_sync == o_level) begin
        deb_cnt <= '0;
      end else if (!(&deb_cnt)) begin
        deb_cnt <= deb_cnt + 1'b1;
      end
      // Level follows the input only once the counter is full
      if (&deb_cnt) begin
        o_level <= sw_sync;
      end
      level_q <= o_level;
      // Registered edge, one cycle after the level rises
      o_pulse <= o_level & ~level_q;
    end
  end

endmodule

`default_nettype wire

//--- hw/host_bridge.sv
// ==========================================================================
// Host bridge
// Four-phase req/ack port onto the frame memories and the step register,
// plus the start control that merges switch and host start requests
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "bilin_consts.svh"

module host_bridge (
  input  logic                       i_clk_50,
  input  logic                       i_rst_n,
  input  logic                       i_host_req,
  input  logic                       i_host_we,
  input  bilin_pkg::host_tgt_e       i_host_tgt,
  input  logic [`BILIN_OUT_AW-1:0]   i_host_addr,
  input  logic [`BILIN_STEP_W-1:0]   i_host_wdata,
  output logic                       o_host_ack,
  output bilin_pkg::pix_t            o_host_rdata,
  input  logic                       i_sw_pulse,
  input  logic                       i_core_busy,
  input  logic                       i_clear_busy,
  output bilin_pkg::in_addr_t        o_in_waddr,
  output bilin_pkg::pix_t            o_in_wdata,
  output logic                       o_in_we,
  output bilin_pkg::out_addr_t       o_out_raddr,
  input  bilin_pkg::pix_t            i_out_rdata,
  output logic [`BILIN_STEP_W-1:0]   o_step,
  output logic                       o_start
);
  import bilin_pkg::*;

  // H_RD covers the registered output-memory read
  typedef enum logic [1:0] {H_IDLE, H_RD, H_LAT, H_ACK} hst_state_e;

  hst_state_e state;
  logic       is_mem;
  logic       hold;
  logic       accept;
  logic       host_start;
  pix_t       rd_sel;

  // Memory targets wait while the core or the clear owns the frames
  assign is_mem     = (i_host_tgt == TGT_IN_MEM) || (i_host_tgt == TGT_OUT_MEM);
  assign hold       = is_mem && (i_core_busy || i_clear_busy);
  assign accept     = (state == H_IDLE) && i_host_req && !hold;
  assign host_start = accept && i_host_we && (i_host_tgt == TGT_START);

  always_comb begin
    case (i_host_tgt)
      TGT_OUT_MEM: rd_sel = i_out_rdata;
      TGT_STEP:    rd_sel = o_step[7:0];
      default:     rd_sel = '0;
    endcase
  end

  // ========================================================================
  // Handshake FSM, step register and start
  // ========================================================================
  always_ff @(posedge i_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= H_IDLE;
      o_host_ack <= 1'b0;
      o_in_we    <= 1'b0;
      o_step     <= `BILIN_STEP_RST;
      o_start    <= 1'b0;
    end else begin
      o_in_we <= 1'b0;
      // Starts are dropped unless everything is idle, back-to-back included
      o_start <= (i_sw_pulse || host_start) && !i_core_busy && !i_clear_busy && !o_start;
      case (state)
        H_IDLE: begin
          if (accept) begin
            o_in_we <= i_host_we && (i_host_tgt == TGT_IN_MEM);
            if (i_host_we && (i_host_tgt == TGT_STEP)) begin
              o_step <= i_host_wdata;
            end
            state <= (!i_host_we && (i_host_tgt == TGT_OUT_MEM)) ? H_RD : H_LAT;
          end
        end
        H_RD:    state <= H_LAT;
        H_LAT: begin
          o_host_ack <= 1'b1;
          state      <= H_ACK;
        end
        H_ACK: begin
          // Release once the host drops req
          if (!i_host_req) begin
            o_host_ack <= 1'b0;
            state      <= H_IDLE;
          end
        end
        default: state <= H_IDLE;
      endcase
    end
  end

  // Address and data captured when the access is taken
  always_ff @(posedge i_clk_50) begin
    if (accept) begin
      o_in_waddr  <= i_host_addr[`BILIN_IN_AW-1:0];
      o_in_wdata  <= i_host_wdata[7:0];
      o_out_raddr <= i_host_addr;
    end
    if (state == H_LAT) begin
      o_host_rdata <= rd_sel;
    end
  end

endmodule

`default_nettype wire

//--- hw/memory/wide_pixel_mem.sv
// ==========================================================================
// Word-wide frame memory
// Byte writes or whole-word fills, two registered read ports
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "bilin_consts.svh"

module wide_pixel_mem (
  input  logic                     i_clk_50,
  pix_rd_if.mem                    rd,
  input  logic [`BILIN_OUT_AW-1:0] i_waddr,
  input  bilin_pkg::pix_t          i_wdata,
  // Bit 0 writes the addressed byte, bit 1 fills all four lanes
  input  logic [1:0]               i_we
);
  import bilin_pkg::*;

  localparam int DEPTH = 1 << (`BILIN_OUT_AW - 2);
  localparam int LANES = `BILIN_WORD_W / `BILIN_PIX_W;

  word_t      mem [DEPTH];
  logic [3:0] lane_en;

  // Low address bits pick the lane for a byte write
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lane_en[k] = i_we[1] | (i_we[0] & (i_waddr[1:0] == 2'(k)));
    end
  end

  always_ff @(posedge i_clk_50) begin
    for (int k = 0; k < LANES; k++) begin
      if (lane_en[k]) begin
        mem[i_waddr[`BILIN_OUT_AW-1:2]][8*k +: 8] <= i_wdata;
      end
    end
    // Both ports read the old word on a same-cycle write
    rd.rdata0 <= mem[rd.raddr0];
    rd.rdata1 <= mem[rd.raddr1];
  end

endmodule

`default_nettype wire

//--- hw/memory/out_frame_buf.sv
// ==========================================================================
// Output frame buffer
// Clears every word after reset, then takes the core's pixel writes;
// host reads return one byte of the registered read word
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "bilin_consts.svh"

module out_frame_buf (
  input  logic                 i_clk_50,
  input  logic                 i_rst_n,
  input  bilin_pkg::out_addr_t i_core_waddr,
  input  bilin_pkg::pix_t      i_core_wdata,
  input  logic                 i_core_we,
  input  bilin_pkg::out_addr_t i_raddr,
  output bilin_pkg::pix_t      o_rdata,
  output logic                 o_clear_busy
);
  import bilin_pkg::*;

  localparam int RW = `BILIN_OUT_AW - 2;

  pix_rd_if u_rd ();

  logic [RW-1:0] clr_cnt;
  out_addr_t     waddr;
  pix_t          wdata;
  logic [1:0]    we;
  logic [1:0]    lane_q;

  // Clear sequencer, one word per cycle
  always_ff @(posedge i_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_clear_busy <= 1'b1;
      clr_cnt      <= '0;
    end else if (o_clear_busy) begin
      clr_cnt <= clr_cnt + 1'b1;
      if (&clr_cnt) begin
        o_clear_busy <= 1'b0;
      end
    end
  end

  // Write source: zero fill during the clear, core afterwards
  always_comb begin
    if (o_clear_busy) begin
      waddr = {clr_cnt, 2'b00};
      wdata = '0;
      we    = 2'b10;
    end else begin
      waddr = i_core_waddr;
      wdata = i_core_wdata;
      we    = {1'b0, i_core_we};
    end
  end

  // Host reads use port 0 only
  assign u_rd.raddr0 = i_raddr[`BILIN_OUT_AW-1:2];
  assign u_rd.raddr1 = '0;

  // Lane select lines up with the registered word
  always_ff @(posedge i_clk_50) begin
    lane_q <= i_raddr[1:0];
  end

  assign o_rdata = u_rd.rdata0[8*lane_q +: 8];

  wide_pixel_mem u_mem (
    .i_clk_50 (i_clk_50),
    .rd       (u_rd.mem),
    .i_waddr  (waddr),
    .i_wdata  (wdata),
    .i_we     (we)
  );

endmodule

`default_nettype wire

//--- hw/bilinear/bilinear_core.sv
// ==========================================================================
// Sequential bilinear core
// Walks the output frame in raster order, fetches four neighbours per
// pixel over two read ports and writes the Q8.8-weighted result
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "bilin_consts.svh"

module bilinear_core (
  input  logic                     i_clk_50,
  input  logic                     i_rst_n,
  input  logic                     i_start,
  input  logic [`BILIN_STEP_W-1:0] i_step,
  pix_rd_if.core                   rd,
  output bilin_pkg::out_addr_t     o_waddr,
  output bilin_pkg::pix_t          o_wdata,
  output logic                     o_we,
  output logic                     o_busy
);
  import bilin_pkg::*;

  localparam int CW = $clog2(`BILIN_IN_W);
  localparam int OW = $clog2(`BILIN_OUT_W);
  localparam int RW = `BILIN_OUT_AW - 2;
  // Output index times step, Q12.8
  localparam int PW = OW + `BILIN_STEP_W;

  core_state_e              state;
  logic [`BILIN_STEP_W-1:0] step_q;
  logic [OW-1:0]            ox;
  logic [OW-1:0]            oy;
  logic [PW-1:0]            sx;
  logic [PW-1:0]            sy;
  logic [CW-1:0]            cx0;
  logic [CW-1:0]            cy0;
  logic [CW-1:0]            x0, x1, y0, y1;
  logic [CW-1:0]            xr;
  logic [7:0]               fx, fy;
  logic [8:0]               wfx, wfy;
  pix_t                     p00, p10;
  logic [15:0]              row_top, row_bot;
  logic [23:0]              acc;
  logic                     last_pix;

  // Integer part limited to the last column or row
  function automatic logic [CW-1:0] clamp_pos(input logic [PW-9:0] ipart, input int lim);
    if (ipart > lim) begin
      return CW'(lim);
    end
    return ipart[CW-1:0];
  endfunction

  function automatic logic [RW-1:0] word_idx(input logic [CW-1:0] y, input logic [CW-1:0] x);
    in_addr_t ba;
    ba = {y, x};
    return RW'(ba >> 2);
  endfunction

  function automatic pix_t pick(input word_t w, input logic [1:0] lane);
    return w[8*lane +: 8];
  endfunction

  // ========================================================================
  // Coordinates and read addresses
  // ========================================================================
  assign sx  = PW'(ox) * PW'(step_q);
  assign sy  = PW'(oy) * PW'(step_q);
  assign cx0 = clamp_pos(sx[PW-1:8], `BILIN_IN_W - 1);
  assign cy0 = clamp_pos(sy[PW-1:8], `BILIN_IN_H - 1);

  // Both rows in flight together, x0 column first, then x1
  assign xr        = (state == CORE_RD_X0) ? x0 : x1;
  assign rd.raddr0 = word_idx(y0, xr);
  assign rd.raddr1 = word_idx(y1, xr);

  // x1 words arrive during CORE_CALC, x0 pixels are already held
  assign wfx     = 9'd256 - {1'b0, fx};
  assign wfy     = 9'd256 - {1'b0, fy};
  assign row_top = p00 * wfx + pick(rd.rdata0, x1[1:0]) * fx;
  assign row_bot = p10 * wfx + pick(rd.rdata1, x1[1:0]) * fx;
  assign acc     = row_top * wfy + row_bot * fy;

  assign last_pix = (ox == OW'(`BILIN_OUT_W - 1)) && (oy == OW'(`BILIN_OUT_H - 1));
  assign o_waddr  = {oy, ox};
  assign o_we     = (state == CORE_WRITE);
  assign o_busy   = (state != CORE_IDLE);

  // ========================================================================
  // Pixel sequencer
  // ========================================================================
  always_ff @(posedge i_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= CORE_IDLE;
      ox    <= '0;
      oy    <= '0;
    end else begin
      case (state)
        CORE_IDLE: begin
          if (i_start) begin
            ox    <= '0;
            oy    <= '0;
            state <= CORE_ADDR;
          end
        end
        CORE_ADDR:  state <= CORE_RD_X0;
        CORE_RD_X0: state <= CORE_RD_X1;
        CORE_RD_X1: state <= CORE_CALC;
        CORE_CALC:  state <= CORE_WRITE;
        CORE_WRITE: begin
          ox <= ox + 1'b1;
          if (&ox) begin
            oy <= oy + 1'b1;
          end
          state <= last_pix ? CORE_IDLE : CORE_ADDR;
        end
        default: state <= CORE_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge i_clk_50) begin
    // Step held for the whole frame
    if ((state == CORE_IDLE) && i_start) begin
      step_q <= i_step;
    end
    if (state == CORE_ADDR) begin
      x0 <= cx0;
      y0 <= cy0;
      x1 <= (cx0 == CW'(`BILIN_IN_W - 1)) ? cx0 : cx0 + 1'b1;
      y1 <= (cy0 == CW'(`BILIN_IN_H - 1)) ? cy0 : cy0 + 1'b1;
      fx <= sx[7:0];
      fy <= sy[7:0];
    end
    if (state == CORE_RD_X1) begin
      p00 <= pick(rd.rdata0, x0[1:0]);
      p10 <= pick(rd.rdata1, x0[1:0]);
    end
    if (state == CORE_CALC) begin
      // Truncate, no rounding
      o_wdata <= acc[23:16];
    end
  end

endmodule

`default_nettype wire

//--- hw/bilin_top.sv
// ==========================================================================
// Bilinear scaler top level
// Switch debounce, host bridge, input frame, core and output frame
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "bilin_consts.svh"

module bilin_top #(
  parameter int DEB_W = 20
) (
  input  logic                     i_clk_50,
  input  logic                     i_rst_n,
  input  logic                     i_host_req,
  input  logic                     i_host_we,
  input  bilin_pkg::host_tgt_e     i_host_tgt,
  input  logic [`BILIN_OUT_AW-1:0] i_host_addr,
  input  logic [`BILIN_STEP_W-1:0] i_host_wdata,
  output logic                     o_host_ack,
  output bilin_pkg::pix_t          o_host_rdata,
  input  logic                     i_start_sw,
  output logic                     o_led_start_on,
  output logic                     o_led_done
);
  import bilin_pkg::*;

  logic                     sw_pulse;
  logic                     start;
  logic [`BILIN_STEP_W-1:0] step;
  logic                     core_busy;
  logic                     clear_busy;
  in_addr_t                 in_waddr;
  pix_t                     in_wdata;
  logic                     in_we;
  out_addr_t                out_raddr;
  pix_t                     out_rdata;
  out_addr_t                core_waddr;
  pix_t                     core_wdata;
  logic                     core_we;
  logic                     run_seen;

  pix_rd_if u_in_rd ();

  start_debounce #(.DEB_W(DEB_W)) u_debounce (
    .i_clk_50 (i_clk_50),
    .i_rst_n  (i_rst_n),
    .i_sw     (i_start_sw),
    .o_level  (o_led_start_on),
    .o_pulse  (sw_pulse)
  );

  host_bridge u_bridge (
    .i_clk_50     (i_clk_50),
    .i_rst_n      (i_rst_n),
    .i_host_req   (i_host_req),
    .i_host_we    (i_host_we),
    .i_host_tgt   (i_host_tgt),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_host_ack   (o_host_ack),
    .o_host_rdata (o_host_rdata),
    .i_sw_pulse   (sw_pulse),
    .i_core_busy  (core_busy),
    .i_clear_busy (clear_busy),
    .o_in_waddr   (in_waddr),
    .o_in_wdata   (in_wdata),
    .o_in_we      (in_we),
    .o_out_raddr  (out_raddr),
    .i_out_rdata  (out_rdata),
    .o_step       (step),
    .o_start      (start)
  );

  // Input frame, byte writes from the host only
  wide_pixel_mem u_in_mem (
    .i_clk_50 (i_clk_50),
    .rd       (u_in_rd.mem),
    .i_waddr  ({2'b00, in_waddr}),
    .i_wdata  (in_wdata),
    .i_we     ({1'b0, in_we})
  );

  bilinear_core u_core (
    .i_clk_50 (i_clk_50),
    .i_rst_n  (i_rst_n),
    .i_start  (start),
    .i_step   (step),
    .rd       (u_in_rd.core),
    .o_waddr  (core_waddr),
    .o_wdata  (core_wdata),
    .o_we     (core_we),
    .o_busy   (core_busy)
  );

  out_frame_buf u_out_buf (
    .i_clk_50     (i_clk_50),
    .i_rst_n      (i_rst_n),
    .i_core_waddr (core_waddr),
    .i_core_wdata (core_wdata),
    .i_core_we    (core_we),
    .i_raddr      (out_raddr),
    .o_rdata      (out_rdata),
    .o_clear_busy (clear_busy)
  );

  // Set by the first start; busy rises on the same edge, so done shows
  // exactly from the edge where busy falls until the next frame begins
  always_ff @(posedge i_clk_50 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      run_seen <= 1'b0;
    end else if (start) begin
      run_seen <= 1'b1;
    end
  end

  assign o_led_done = run_seen & ~core_busy;

endmodule

`default_nettype wire

//--- dv/bilin_assertions.sv
// ==========================================================================
// Host bridge assertions
// Four-phase handshake order and start pulse rules, bound into host_bridge
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

module bilin_assertions (
  input logic i_clk_50,
  input logic i_rst_n,
  input logic i_host_req,
  input logic i_host_ack,
  input logic i_start,
  input logic i_core_busy,
  input logic i_clear_busy
);

  // Ack only answers a pending request
  ack_needs_req: assert property (@(posedge i_clk_50) disable iff (!i_rst_n)
    $rose(i_host_ack) |-> i_host_req)
    else $error("host ack rose without a request");

  // Release one cycle after the host drops req
  ack_follows_req: assert property (@(posedge i_clk_50) disable iff (!i_rst_n)
    $fell(i_host_req) |=> $fell(i_host_ack))
    else $error("host ack did not fall one cycle after req");

  start_one_cycle: assert property (@(posedge i_clk_50) disable iff (!i_rst_n)
    i_start |=> !i_start)
    else $error("start pulse longer than one cycle");

  // Core and clear both idle when a frame starts
  start_when_idle: assert property (@(posedge i_clk_50) disable iff (!i_rst_n)
    i_start |-> (!i_core_busy && !i_clear_busy))
    else $error("start issued while the core or the clear was busy");

endmodule

bind host_bridge bilin_assertions u_assertions (
  .i_clk_50     (i_clk_50),
  .i_rst_n      (i_rst_n),
  .i_host_req   (i_host_req),
  .i_host_ack   (o_host_ack),
  .i_start      (o_start),
  .i_core_busy  (i_core_busy),
  .i_clear_busy (i_clear_busy)
);

`default_nettype wire

//--- dv/bilin_tb.sv
// ==========================================================================
// Bilinear scaler testbench
// Table-driven frames through the host port and the start switch,
// checked against a bilinear reference model of the input image
// ==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "bilin_consts.svh"

module bilin_tb;
  import bilin_pkg::*;

  localparam int DEB_W     = 4;
  localparam int CLK_NS    = 10;
  localparam int IN_PIX    = `BILIN_IN_W * `BILIN_IN_H;
  localparam int OUT_PIX   = `BILIN_OUT_W * `BILIN_OUT_H;
  // Five core states per output pixel
  localparam int FRAME_CYC = 5 * OUT_PIX;
  localparam int ACK_LIMIT = FRAME_CYC + 200;
  localparam int SW_HOLD   = 4 << DEB_W;
  // Worst test: image load, frame, full readback and switch presses
  localparam int TEST_CYC  = 6 * IN_PIX + FRAME_CYC + 8 * OUT_PIX + 3 * SW_HOLD + 200;
  localparam int N_TESTS   = 7;

  typedef enum logic [1:0] {SRC_NONE, SRC_HOST, SRC_SWITCH} start_src_e;
  typedef enum logic [2:0] {CHK_ZERO, CHK_MODEL, CHK_IDENT, CHK_REPEAT, CHK_BUSY} check_e;

  // One table row: step to load, how the frame starts, what is checked
  typedef struct packed {
    logic [15:0] step;
    start_src_e  src;
    check_e      kind;
  } test_t;

  logic        clk_50;
  logic        rst_n;
  logic        host_req;
  logic        host_we;
  host_tgt_e   host_tgt;
  logic [7:0]  host_addr;
  logic [15:0] host_wdata;
  logic        host_ack;
  pix_t        host_rdata;
  logic        start_sw;
  logic        led_start_on;
  logic        led_done;

  test_t tests [N_TESTS];
  pix_t  img [IN_PIX];
  pix_t  prev_img [OUT_PIX];
  logic  img_loaded;
  logic  done_at_ack;
  int    error_cnt;
  int    check_cnt;
  int    fail_cnt;

  bilin_top #(.DEB_W(DEB_W)) u_bilin_top (
    .i_clk_50       (clk_50),
    .i_rst_n        (rst_n),
    .i_host_req     (host_req),
    .i_host_we      (host_we),
    .i_host_tgt     (host_tgt),
    .i_host_addr    (host_addr),
    .i_host_wdata   (host_wdata),
    .o_host_ack     (host_ack),
    .o_host_rdata   (host_rdata),
    .i_start_sw     (start_sw),
    .o_led_start_on (led_start_on),
    .o_led_done     (led_done)
  );

  initial begin
    clk_50 = 1'b0;
    forever #(CLK_NS / 2) clk_50 = ~clk_50;
  end

  // Watchdog sized from the table length
  initial begin
    #((N_TESTS * TEST_CYC + 1000) * CLK_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("tests failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Reference pixel from the Q8.8 rule, edges clamped
  function automatic pix_t bilinear_ref(input int ox, input int oy, input logic [15:0] step);
    int sx, sy, x0, x1, y0, y1;
    int fx, fy, top, bot;
    sx = ox * int'(step);
    sy = oy * int'(step);
    x0 = sx >> 8;
    y0 = sy >> 8;
    if (x0 > `BILIN_IN_W - 1) x0 = `BILIN_IN_W - 1;
    if (y0 > `BILIN_IN_H - 1) y0 = `BILIN_IN_H - 1;
    x1 = (x0 < `BILIN_IN_W - 1) ? x0 + 1 : x0;
    y1 = (y0 < `BILIN_IN_H - 1) ? y0 + 1 : y0;
    fx = sx & 255;
    fy = sy & 255;
    top = int'(img[y0 * `BILIN_IN_W + x0]) * (256 - fx) + int'(img[y0 * `BILIN_IN_W + x1]) * fx;
    bot = int'(img[y1 * `BILIN_IN_W + x0]) * (256 - fx) + int'(img[y1 * `BILIN_IN_W + x1]) * fx;
    return pix_t'((top * (256 - fy) + bot * fy) >> 16);
  endfunction

  // Four-phase access, rdata and done sampled while ack is high
  task automatic host_access(input logic we, input host_tgt_e tgt, input logic [7:0] addr,
                             input logic [15:0] wdata, output pix_t rdata);
    int waited;
    @(posedge clk_50);
    host_req   <= 1'b1;
    host_we    <= we;
    host_tgt   <= tgt;
    host_addr  <= addr;
    host_wdata <= wdata;
    waited = 0;
    do begin
      @(negedge clk_50);
      waited++;
    end while (!host_ack && waited < ACK_LIMIT);
    if (!host_ack) begin
      error_cnt++;
      $display("host access to %s at 0x%0h never got an ack", tgt.name(), addr);
    end
    rdata       = host_rdata;
    done_at_ack = led_done;
    @(posedge clk_50);
    host_req <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk_50);
      waited++;
    end while (host_ack && waited < 8);
    if (host_ack) begin
      error_cnt++;
      $display("ack stayed high after req was dropped");
    end
  endtask

  task automatic load_image();
    pix_t unused;
    for (int i = 0; i < IN_PIX; i++) begin
      img[i] = pix_t'($urandom);
      host_access(1'b1, TGT_IN_MEM, 8'(i), {8'h00, img[i]}, unused);
    end
    img_loaded = 1'b1;
  endtask

  // Done falls as the frame starts, rises as busy ends
  task automatic wait_frame_done();
    int waited;
    waited = 0;
    while (led_done && waited < 50) begin
      @(negedge clk_50);
      waited++;
    end
    if (led_done) begin
      error_cnt++;
      $display("frame did not start, o_led_done stayed high");
    end
    waited = 0;
    while (!led_done && waited < ACK_LIMIT) begin
      @(negedge clk_50);
      waited++;
    end
    if (!led_done) begin
      error_cnt++;
      $display("frame did not finish, o_led_done stayed low");
    end
  endtask

  task automatic switch_start();
    // A press shorter than the debounce time never reaches the level
    @(posedge clk_50);
    start_sw <= 1'b1;
    repeat (2) @(posedge clk_50);
    start_sw <= 1'b0;
    repeat (SW_HOLD) @(posedge clk_50);
    @(negedge clk_50);
    check_value("o_led_start_on after short press", led_start_on, 0);
    @(posedge clk_50);
    start_sw <= 1'b1;
    repeat (SW_HOLD) @(posedge clk_50);
    @(negedge clk_50);
    check_value("o_led_start_on", led_start_on, 1);
    @(posedge clk_50);
    start_sw <= 1'b0;
    // Level falls, counter refills for the next press
    repeat (SW_HOLD) @(posedge clk_50);
    @(negedge clk_50);
    check_value("o_led_start_on released", led_start_on, 0);
  endtask

  task automatic check_clear();
    pix_t got;
    // Reads wait in the bridge until the clear is over
    for (int i = 0; i < 16; i++) begin
      host_access(1'b0, TGT_OUT_MEM, 8'(i * 17), 16'h0, got);
      check_value($sformatf("o_host_rdata cleared 0x%02h", i * 17), got, 0);
    end
    check_value("o_led_done after clear", led_done, 0);
  endtask

  task automatic read_frame(input test_t t);
    pix_t got;
    pix_t exp;
    int   a;
    int   ix;
    int   iy;
    for (int oy = 0; oy < `BILIN_OUT_H; oy++) begin
      for (int ox = 0; ox < `BILIN_OUT_W; ox++) begin
        a  = oy * `BILIN_OUT_W + ox;
        ix = (ox < `BILIN_IN_W) ? ox : `BILIN_IN_W - 1;
        iy = (oy < `BILIN_IN_H) ? oy : `BILIN_IN_H - 1;
        host_access(1'b0, TGT_OUT_MEM, 8'(a), 16'h0, got);
        // Unit step copies input pixels, edge repeated
        if (t.kind == CHK_IDENT) begin
          exp = img[iy * `BILIN_IN_W + ix];
        end else begin
          exp = bilinear_ref(ox, oy, t.step);
        end
        check_value($sformatf("o_host_rdata (%0d,%0d)", ox, oy), got, exp);
        if (t.kind == CHK_REPEAT) begin
          check_value($sformatf("o_host_rdata repeat (%0d,%0d)", ox, oy), got, prev_img[a]);
        end
        prev_img[a] = got;
      end
    end
  endtask

  // Read held behind a running frame, then the step readback
  task automatic check_busy_read(input logic [15:0] step);
    pix_t got;
    check_value("o_led_done before held read", led_done, 0);
    host_access(1'b0, TGT_OUT_MEM, 8'(OUT_PIX - 1), 16'h0, got);
    check_value("o_led_done at held ack", done_at_ack, 1);
    check_value("o_host_rdata last pixel", got,
                bilinear_ref(`BILIN_OUT_W - 1, `BILIN_OUT_H - 1, step));
    host_access(1'b0, TGT_STEP, 8'h00, 16'h0, got);
    check_value("o_host_rdata step low byte", got, step[7:0]);
  endtask

  task automatic run_test(input int idx);
    test_t  t;
    check_e kind;
    int     errs_before;
    pix_t   unused;
    t           = tests[idx];
    kind        = t.kind;
    errs_before = error_cnt;
    if (kind == CHK_ZERO) begin
      check_clear();
    end else begin
      if (!img_loaded) begin
        load_image();
      end
      host_access(1'b1, TGT_STEP, 8'h00, t.step, unused);
      if (t.src == SRC_SWITCH) begin
        switch_start();
      end else begin
        host_access(1'b1, TGT_START, 8'h00, 16'h0, unused);
      end
      if (kind == CHK_BUSY) begin
        check_busy_read(t.step);
      end else begin
        wait_frame_done();
        read_frame(t);
      end
    end
    if (error_cnt != errs_before) begin
      fail_cnt++;
    end
    $display("test %0d step 0x%04h %s: %s", idx, t.step, kind.name(),
             (error_cnt == errs_before) ? "ok" : "FAILED");
  endtask

  task automatic fill_table();
    tests[0] = '{step: 16'h0080, src: SRC_NONE,   kind: CHK_ZERO};
    tests[1] = '{step: 16'h0080, src: SRC_HOST,   kind: CHK_MODEL};
    tests[2] = '{step: 16'h0100, src: SRC_HOST,   kind: CHK_IDENT};
    tests[3] = '{step: 16'h0080, src: SRC_SWITCH, kind: CHK_MODEL};
    tests[4] = '{step: 16'h0080, src: SRC_SWITCH, kind: CHK_REPEAT};
    tests[5] = '{step: 16'h00c0, src: SRC_HOST,   kind: CHK_BUSY};
    tests[6] = '{step: 16'h0133, src: SRC_HOST,   kind: CHK_MODEL};
  endtask

  // ========================================================================
  // Main sequence
  // ========================================================================
  initial begin
    void'($urandom(32'he936));
    rst_n       = 1'b0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_tgt    = TGT_IN_MEM;
    host_addr   = 8'h00;
    host_wdata  = 16'h0000;
    start_sw    = 1'b0;
    img_loaded  = 1'b0;
    done_at_ack = 1'b0;
    error_cnt   = 0;
    check_cnt   = 0;
    fail_cnt    = 0;
    fill_table();
    repeat (3) @(posedge clk_50);
    rst_n <= 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      run_test(i);
    end
    $display("summary: %0d tests run, %0d with errors, %0d checks, %0d mismatches",
             N_TESTS, fail_cnt, check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+common
common/bilin_pkg.sv
common/pix_rd_if.sv
hw/start_debounce.sv
hw/host_bridge.sv
hw/memory/wide_pixel_mem.sv
hw/memory/out_frame_buf.sv
hw/bilinear/bilinear_core.sv
hw/bilin_top.sv
dv/bilin_assertions.sv
dv/bilin_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the bilinear scaler testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bilin_tb \
  -f compile.f --Mdir "$BUILD_DIR" -o bilin_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/bilin_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished clean"
exit 0
